// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/host_ctrl_pkg.sv ====
// Port identifiers and flush controller state; port ids double as array indices
`default_nettype none

package host_ctrl_pkg;

    localparam int unsigned NUM_PORTS = 3;

    typedef enum logic [1:0] {
        PORT_INSTR  = 2'd0,
        PORT_DATA   = 2'd1,
        PORT_BYPASS = 2'd2
    } port_id_e;

    typedef enum logic {
        FLUSH_IDLE    = 1'b0,
        FLUSH_PENDING = 1'b1
    } flush_state_e;

endpackage

`default_nettype wire

// ==== design/host_flush_ctrl.sv ====
// Host word snoop and flush flag; only full word addresses match, instruction writes are ignored
`timescale 1ns/1ps
`default_nettype none

`include "host_mem_cfg.svh"

module host_flush_ctrl import mem_types_pkg::*; import host_ctrl_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    mem_req_if.mon                 data,
    mem_req_if.mon                 bypass,
    input  logic                   flush_req_i,
    input  logic                   flush_ack_i,
    output logic                   flushing_o,
    output logic                   tohost_valid_o,
    output logic [`MEM_DATA_W-1:0] tohost_data_o
);

    logic [NUM_PORTS-1:0]   snoop_valid;
    mem_req_t               snoop_req [NUM_PORTS];
    logic [NUM_PORTS-1:0]   host_hit;
    logic [NUM_PORTS-1:0]   tohost_hit;
    port_id_e               sel_port;
    flush_state_e           state_q;
    logic                   tohost_valid_q;
    logic [`MEM_DATA_W-1:0] tohost_data_q;

    // Disabled bytes read as zero
    function automatic logic [`MEM_DATA_W-1:0] masked_wdata(mem_req_t r);
        logic [`MEM_DATA_W-1:0] m;
        for (int b = 0; b < `MEM_BE_W; b++) begin
            m[8*b +: 8] = r.be[b] ? r.wdata[8*b +: 8] : 8'h00;
        end
        return m;
    endfunction

    // Instruction port is not snooped
    assign snoop_valid[PORT_INSTR]  = 1'b0;
    assign snoop_valid[PORT_DATA]   = data.valid;
    assign snoop_valid[PORT_BYPASS] = bypass.valid;
    assign snoop_req[PORT_INSTR]    = '0;
    assign snoop_req[PORT_DATA]     = data.req;
    assign snoop_req[PORT_BYPASS]   = bypass.req;

    always_comb begin
        host_hit   = '0;
        tohost_hit = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (snoop_valid[p] && snoop_req[p].we && snoop_req[p].in_range) begin
                tohost_hit[p] = (snoop_req[p].addr.raw == `TOHOST_ADDR);
                host_hit[p]   = tohost_hit[p] || (snoop_req[p].addr.raw == `FROMHOST_ADDR);
            end
        end
    end

    // Data port wins the tohost capture
    assign sel_port = tohost_hit[PORT_DATA] ? PORT_DATA : PORT_BYPASS;

    // ----------------------------------------------------------------------
    // Flush flag and tohost capture
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q        <= FLUSH_IDLE;
            tohost_valid_q <= 1'b0;
        end else begin
            tohost_valid_q <= |tohost_hit;
            // New trigger beats an acknowledge in the same cycle
            if (flush_req_i || (|host_hit)) begin
                state_q <= FLUSH_PENDING;
            end else if (flush_ack_i) begin
                state_q <= FLUSH_IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (|tohost_hit) begin
            tohost_data_q <= masked_wdata(snoop_req[sel_port]);
        end
    end

    assign flushing_o     = (state_q == FLUSH_PENDING);
    assign tohost_valid_o = tohost_valid_q;
    assign tohost_data_o  = tohost_data_q;

endmodule

`default_nettype wire

// ==== design/mem_port_in.sv ====
// Request input stage; low address bits are dropped, accesses are always whole 64-bit words
`timescale 1ns/1ps
`default_nettype none

`include "host_mem_cfg.svh"

module mem_port_in import mem_types_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   req_i,
    input  logic                   we_i,
    input  logic [`MEM_ADDR_W-1:0] addr_i,
    input  logic [`MEM_BE_W-1:0]   be_i,
    input  logic [`MEM_DATA_W-1:0] wdata_i,
    mem_req_if.src                 out
);

    mem_addr_u addr_d;
    mem_req_t  req_d;
    mem_req_t  req_q;
    logic      valid_q;

    // ----------------------------------------------------------------------
    // Decode
    // ----------------------------------------------------------------------
    always_comb begin
        addr_d       = mem_addr_u'(addr_i);
        // Word aligned
        addr_d.f.off = '0;

        req_d.addr     = addr_d;
        // A write with no byte enabled becomes a read
        req_d.we       = we_i & (|be_i);
        req_d.be       = be_i;
        req_d.wdata    = wdata_i;
        req_d.in_range = (addr_d.f.tag == `MEM_BASE_TAG);
    end

    // ----------------------------------------------------------------------
    // Request register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i;
        end
    end

    // Payload only follows a real strobe
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            req_q <= req_d;
        end
    end

    assign out.valid = valid_q;
    assign out.req   = req_q;

endmodule

`default_nettype wire

// ==== design/mem_req_if.sv ====
// Registered single-cycle request strobe; no back-pressure, receiver must take it at once
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if import mem_types_pkg::*; ();

    // High for exactly one cycle per request
    logic     valid;
    mem_req_t req;

    // Port stage side
    modport src (
        output valid,
        output req
    );

    // Memory side
    modport dst (
        input valid,
        input req
    );

    // Snoop side
    modport mon (
        input valid,
        input req
    );

endinterface

`default_nettype wire

// ==== design/mem_subsys_top.sv ====
// Memory subsystem top; strobes carry no back-pressure and every response comes two cycles later
`timescale 1ns/1ps
`default_nettype none

`include "host_mem_cfg.svh"

module mem_subsys_top import mem_types_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Instruction port
    input  logic                   instr_req_i,
    input  logic                   instr_we_i,
    input  logic [`MEM_ADDR_W-1:0] instr_addr_i,
    input  logic [`MEM_BE_W-1:0]   instr_be_i,
    input  logic [`MEM_DATA_W-1:0] instr_wdata_i,
    output logic                   instr_rvalid_o,
    output logic [`MEM_DATA_W-1:0] instr_rdata_o,
    output logic                   instr_err_o,
    // Data port
    input  logic                   data_req_i,
    input  logic                   data_we_i,
    input  logic [`MEM_ADDR_W-1:0] data_addr_i,
    input  logic [`MEM_BE_W-1:0]   data_be_i,
    input  logic [`MEM_DATA_W-1:0] data_wdata_i,
    output logic                   data_rvalid_o,
    output logic [`MEM_DATA_W-1:0] data_rdata_o,
    output logic                   data_err_o,
    // Bypass port
    input  logic                   bypass_req_i,
    input  logic                   bypass_we_i,
    input  logic [`MEM_ADDR_W-1:0] bypass_addr_i,
    input  logic [`MEM_BE_W-1:0]   bypass_be_i,
    input  logic [`MEM_DATA_W-1:0] bypass_wdata_i,
    output logic                   bypass_rvalid_o,
    output logic [`MEM_DATA_W-1:0] bypass_rdata_o,
    output logic                   bypass_err_o,
    // Host flush control
    input  logic                   flush_req_i,
    input  logic                   flush_ack_i,
    output logic                   flushing_o,
    output logic                   tohost_valid_o,
    output logic [`MEM_DATA_W-1:0] tohost_data_o
);

    mem_resp_t instr_resp;
    mem_resp_t data_resp;
    mem_resp_t bypass_resp;

    mem_req_if instr_if ();
    mem_req_if data_if ();
    mem_req_if bypass_if ();

    // ----------------------------------------------------------------------
    // Input stages
    // ----------------------------------------------------------------------
    mem_port_in i_port_instr (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (instr_req_i),
        .we_i    (instr_we_i),
        .addr_i  (instr_addr_i),
        .be_i    (instr_be_i),
        .wdata_i (instr_wdata_i),
        .out     (instr_if)
    );

    mem_port_in i_port_data (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (data_req_i),
        .we_i    (data_we_i),
        .addr_i  (data_addr_i),
        .be_i    (data_be_i),
        .wdata_i (data_wdata_i),
        .out     (data_if)
    );

    mem_port_in i_port_bypass (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (bypass_req_i),
        .we_i    (bypass_we_i),
        .addr_i  (bypass_addr_i),
        .be_i    (bypass_be_i),
        .wdata_i (bypass_wdata_i),
        .out     (bypass_if)
    );

    // ----------------------------------------------------------------------
    // Memory and host snoop
    // ----------------------------------------------------------------------
    sim_mem_array i_mem (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .instr           (instr_if),
        .data            (data_if),
        .bypass          (bypass_if),
        .instr_resp_o    (instr_resp),
        .data_resp_o     (data_resp),
        .bypass_resp_o   (bypass_resp),
        .instr_rvalid_o  (instr_rvalid_o),
        .data_rvalid_o   (data_rvalid_o),
        .bypass_rvalid_o (bypass_rvalid_o)
    );

    host_flush_ctrl i_flush (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .data           (data_if),
        .bypass         (bypass_if),
        .flush_req_i    (flush_req_i),
        .flush_ack_i    (flush_ack_i),
        .flushing_o     (flushing_o),
        .tohost_valid_o (tohost_valid_o),
        .tohost_data_o  (tohost_data_o)
    );

    assign instr_rdata_o  = instr_resp.rdata;
    assign instr_err_o    = instr_resp.err;
    assign data_rdata_o   = data_resp.rdata;
    assign data_err_o     = data_resp.err;
    assign bypass_rdata_o = bypass_resp.rdata;
    assign bypass_err_o   = bypass_resp.err;

endmodule

`default_nettype wire

// ==== design/mem_types_pkg.sv ====
// Address, request and response types; byte offset is always 3 bits for 64-bit words
`default_nettype none

`include "host_mem_cfg.svh"

package mem_types_pkg;

    localparam int unsigned MEM_OFF_W = 3;
    localparam int unsigned MEM_TAG_W = `MEM_ADDR_W - `MEM_IDX_W - MEM_OFF_W;

    typedef struct packed {
        logic [MEM_TAG_W-1:0]  tag;
        logic [`MEM_IDX_W-1:0] idx;
        logic [MEM_OFF_W-1:0]  off;
    } mem_addr_fields_t;

    // Raw view for host word compares, field view for indexing
    typedef union packed {
        logic [`MEM_ADDR_W-1:0] raw;
        mem_addr_fields_t       f;
    } mem_addr_u;

    typedef struct packed {
        mem_addr_u              addr;
        logic                   we;
        logic [`MEM_BE_W-1:0]   be;
        logic [`MEM_DATA_W-1:0] wdata;
        logic                   in_range;
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_DATA_W-1:0] rdata;
        logic                   err;
    } mem_resp_t;

endpackage

`default_nettype wire

// ==== design/sim_mem_array.sv ====
// Three-port word memory with no initial contents; same-word write collisions drop the loser
`timescale 1ns/1ps
`default_nettype none

`include "host_mem_cfg.svh"

module sim_mem_array import mem_types_pkg::*; import host_ctrl_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    mem_req_if.dst    instr,
    mem_req_if.dst    data,
    mem_req_if.dst    bypass,
    output mem_resp_t instr_resp_o,
    output mem_resp_t data_resp_o,
    output mem_resp_t bypass_resp_o,
    output logic      instr_rvalid_o,
    output logic      data_rvalid_o,
    output logic      bypass_rvalid_o
);

    localparam int unsigned NUM_WORDS = 2 ** `MEM_IDX_W;

    // Highest write priority first
    localparam port_id_e WR_PRIO [NUM_PORTS] = '{PORT_DATA, PORT_BYPASS, PORT_INSTR};

    logic [`MEM_DATA_W-1:0] mem_q [NUM_WORDS];

    logic [NUM_PORTS-1:0] port_valid;
    mem_req_t             port_req [NUM_PORTS];
    logic [NUM_PORTS-1:0] wr_req;
    logic [NUM_PORTS-1:0] wr_en;
    logic [NUM_PORTS-1:0] rvalid_q;
    mem_resp_t            resp_q [NUM_PORTS];

    assign port_valid[PORT_INSTR]  = instr.valid;
    assign port_valid[PORT_DATA]   = data.valid;
    assign port_valid[PORT_BYPASS] = bypass.valid;

    assign port_req[PORT_INSTR]  = instr.req;
    assign port_req[PORT_DATA]   = data.req;
    assign port_req[PORT_BYPASS] = bypass.req;

    // ----------------------------------------------------------------------
    // Write arbitration
    // ----------------------------------------------------------------------
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            wr_req[p] = port_valid[p] && port_req[p].we && port_req[p].in_range;
        end
        wr_en = wr_req;
        // Any higher priority write to the same word cancels this one
        for (int i = 1; i < NUM_PORTS; i++) begin
            for (int j = 0; j < i; j++) begin
                if (wr_req[WR_PRIO[j]] &&
                    port_req[WR_PRIO[j]].addr.f.idx == port_req[WR_PRIO[i]].addr.f.idx) begin
                    wr_en[WR_PRIO[i]] = 1'b0;
                end
            end
        end
    end

    // Byte merged write, lands at the next edge
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (wr_en[p]) begin
                for (int b = 0; b < `MEM_BE_W; b++) begin
                    if (port_req[p].be[b]) begin
                        mem_q[port_req[p].addr.f.idx][8*b +: 8] <= port_req[p].wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Responses
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= '0;
        end else begin
            rvalid_q <= port_valid;
        end
    end

    // Reads see the contents before this cycle's writes
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (port_valid[p]) begin
                resp_q[p].err <= !port_req[p].in_range;
                if (port_req[p].in_range && !port_req[p].we) begin
                    resp_q[p].rdata <= mem_q[port_req[p].addr.f.idx];
                end else begin
                    resp_q[p].rdata <= '0;
                end
            end
        end
    end

    assign instr_resp_o    = resp_q[PORT_INSTR];
    assign data_resp_o     = resp_q[PORT_DATA];
    assign bypass_resp_o   = resp_q[PORT_BYPASS];
    assign instr_rvalid_o  = rvalid_q[PORT_INSTR];
    assign data_rvalid_o   = rvalid_q[PORT_DATA];
    assign bypass_rvalid_o = rvalid_q[PORT_BYPASS];

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
design/mem_types_pkg.sv
design/host_ctrl_pkg.sv
design/mem_req_if.sv
design/mem_port_in.sv
design/sim_mem_array.sv
design/host_flush_ctrl.sv
design/mem_subsys_top.sv
testbench/mem_subsys_assertions.sv
testbench/tb_mem_subsys.sv

// ==== include/host_mem_cfg.svh ====
// Fixed geometry of the simulation memory; the host words must lie inside the memory window
`ifndef HOST_MEM_CFG_SVH
`define HOST_MEM_CFG_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define MEM_ADDR_W 32
`define MEM_DATA_W 64
`define MEM_BE_W 8

// Word index width, 1024 words of 64 bits
`define MEM_IDX_W 10

// ----------------------------------------------------------------------
// Address map
// ----------------------------------------------------------------------
// Upper 19 address bits of the base address 0x8000_0000
`define MEM_BASE_TAG 19'h4_0000

// Host communication words
`define TOHOST_ADDR 32'h8000_1000
`define FROMHOST_ADDR 32'h8000_1040

`endif

// ==== testbench/mem_subsys_assertions.sv ====
// Protocol assertions bound to mem_subsys_top; checks are disabled while reset is low
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_assertions (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic instr_req_i,
    input wire logic data_req_i,
    input wire logic data_we_i,
    input wire logic bypass_req_i,
    input wire logic bypass_we_i,
    input wire logic instr_rvalid_o,
    input wire logic data_rvalid_o,
    input wire logic bypass_rvalid_o,
    input wire logic flush_req_i,
    input wire logic flushing_o,
    input wire logic tohost_valid_o
);

    // ----------------------------------------------------------------------
    // Response follows a strobe two cycles earlier
    // ----------------------------------------------------------------------
    a_instr_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_rvalid_o |-> $past(instr_req_i, 2))
        else $error("instr rvalid without request");

    a_data_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_rvalid_o |-> $past(data_req_i, 2))
        else $error("data rvalid without request");

    a_bypass_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bypass_rvalid_o |-> $past(bypass_req_i, 2))
        else $error("bypass rvalid without request");

    // Flag rises on an external request or a snooped write
    a_flush_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(flushing_o) |-> ($past(flush_req_i) ||
            $past(data_req_i && data_we_i, 2) || $past(bypass_req_i && bypass_we_i, 2)))
        else $error("flushing_o rose without trigger");

    a_tohost_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tohost_valid_o |=> !tohost_valid_o)
        else $error("tohost_valid_o longer than one cycle");

endmodule

bind mem_subsys_top mem_subsys_assertions i_assertions (.*);

`default_nettype wire

// ==== testbench/tb_mem_subsys.sv ====
// Random testbench for mem_subsys_top; assumes fixed two-cycle response latency and a preloaded memory
`timescale 1ns/1ps
`default_nettype none

`include "host_mem_cfg.svh"

module tb_mem_subsys;

    localparam int unsigned NP = 3;
    localparam int unsigned WORDS = 2 ** `MEM_IDX_W;

    logic clk_i = 1'b0;
    logic rst_ni = 1'b0;

    // Port index 0 instruction, 1 data, 2 bypass
    logic                   req [NP];
    logic                   we [NP];
    logic [`MEM_ADDR_W-1:0] addr [NP];
    logic [`MEM_BE_W-1:0]   be [NP];
    logic [`MEM_DATA_W-1:0] wdata [NP];
    logic                   rvalid [NP];
    logic [`MEM_DATA_W-1:0] rdata [NP];
    logic                   err [NP];
    logic                   flush_req;
    logic                   flush_ack;
    logic                   flushing;
    logic                   tohost_valid;
    logic [`MEM_DATA_W-1:0] tohost_data;

    integer seed = 42;
    int     errors = 0;
    int     checks = 0;
    int     test_start = 0;

    // Reference model state
    logic [`MEM_DATA_W-1:0] ref_mem [int unsigned];
    logic                   exp_v [NP];
    logic [`MEM_DATA_W-1:0] exp_d [NP];
    logic                   exp_e [NP];
    logic                   flag_q;
    logic                   prev_hit;
    logic                   prev_th;
    logic [`MEM_DATA_W-1:0] prev_td;

    always #4 clk_i = ~clk_i;

    mem_subsys_top mem_subsys_top_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .instr_req_i     (req[0]),
        .instr_we_i      (we[0]),
        .instr_addr_i    (addr[0]),
        .instr_be_i      (be[0]),
        .instr_wdata_i   (wdata[0]),
        .instr_rvalid_o  (rvalid[0]),
        .instr_rdata_o   (rdata[0]),
        .instr_err_o     (err[0]),
        .data_req_i      (req[1]),
        .data_we_i       (we[1]),
        .data_addr_i     (addr[1]),
        .data_be_i       (be[1]),
        .data_wdata_i    (wdata[1]),
        .data_rvalid_o   (rvalid[1]),
        .data_rdata_o    (rdata[1]),
        .data_err_o      (err[1]),
        .bypass_req_i    (req[2]),
        .bypass_we_i     (we[2]),
        .bypass_addr_i   (addr[2]),
        .bypass_be_i     (be[2]),
        .bypass_wdata_i  (wdata[2]),
        .bypass_rvalid_o (rvalid[2]),
        .bypass_rdata_o  (rdata[2]),
        .bypass_err_o    (err[2]),
        .flush_req_i     (flush_req),
        .flush_ack_i     (flush_ack),
        .flushing_o      (flushing),
        .tohost_valid_o  (tohost_valid),
        .tohost_data_o   (tohost_data)
    );

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    function automatic logic [`MEM_DATA_W-1:0] fill_word(int unsigned i);
        logic [31:0] a;
        a = {`MEM_BASE_TAG, i[9:0], 3'b000};
        return {a ^ 32'h5A5A_C3C3, ~a};
    endfunction

    // Host words are kept out of the random address space
    function automatic logic [31:0] rand_addr(logic [9:0] mask);
        logic [9:0] i;
        logic [2:0] off;
        i = 10'($random(seed)) & mask;
        off = 3'($random(seed));
        if (i == 10'h200 || i == 10'h208) begin
            i = i ^ 10'h001;
        end
        return {`MEM_BASE_TAG, i, off};
    endfunction

    function automatic logic [31:0] rand_oor();
        logic [18:0] t;
        t = 19'($random(seed));
        if (t == `MEM_BASE_TAG) begin
            t = t ^ 19'h1;
        end
        return {t, 13'($random(seed))};
    endfunction

    task automatic check_val(string name, logic [63:0] exp_val, logic [63:0] got);
        checks++;
        if (got !== exp_val) begin
            $display("FAILED t=%0t %s exp=%h got=%h", $time, name, exp_val, got);
            errors++;
        end
    endtask

    task automatic clear_inputs();
        for (int p = 0; p < NP; p++) begin
            req[p] = 1'b0;
            we[p] = 1'b0;
            addr[p] = '0;
            be[p] = '0;
            wdata[p] = '0;
        end
        flush_req = 1'b0;
        flush_ack = 1'b0;
    endtask

    // Model one clock of the current inputs, advance, then check outputs
    task automatic step();
        logic                   nv [NP];
        logic [`MEM_DATA_W-1:0] nd [NP];
        logic                   ne [NP];
        logic                   wreq [NP];
        logic                   wr [NP];
        logic [9:0]             idx [NP];
        logic                   inr;
        logic                   hit;
        logic                   th;
        logic [`MEM_DATA_W-1:0] tdat;
        logic                   new_flag;
        logic [31:0]            wa;
        string                  names [NP];
        names = '{"instr", "data", "bypass"};
        hit = 1'b0;
        th = 1'b0;
        tdat = '0;
        for (int p = 0; p < NP; p++) begin
            inr = (addr[p][31:13] == `MEM_BASE_TAG);
            idx[p] = addr[p][12:3];
            wreq[p] = req[p] && we[p] && (be[p] != 0) && inr;
            nv[p] = req[p];
            ne[p] = !inr;
            nd[p] = (inr && !wreq[p]) ? ref_mem[idx[p]] : '0;
        end
        // Data beats bypass beats instruction; a loser is dropped whole
        wr = wreq;
        if (wreq[1] && wreq[2] && idx[1] == idx[2]) begin
            wr[2] = 1'b0;
        end
        if (wreq[0] && ((wreq[1] && idx[1] == idx[0]) || (wreq[2] && idx[2] == idx[0]))) begin
            wr[0] = 1'b0;
        end
        for (int p = 0; p < NP; p++) begin
            if (wr[p]) begin
                for (int b = 0; b < 8; b++) begin
                    if (be[p][b]) begin
                        ref_mem[idx[p]][8*b +: 8] = wdata[p][8*b +: 8];
                    end
                end
            end
        end
        for (int p = 2; p >= 1; p--) begin
            wa = {addr[p][31:3], 3'b000};
            if (wreq[p] && (wa == `TOHOST_ADDR || wa == `FROMHOST_ADDR)) begin
                hit = 1'b1;
            end
            if (wreq[p] && wa == `TOHOST_ADDR) begin
                th = 1'b1;
                for (int b = 0; b < 8; b++) begin
                    tdat[8*b +: 8] = be[p][b] ? wdata[p][8*b +: 8] : 8'h00;
                end
            end
        end
        new_flag = (flush_req || prev_hit) ? 1'b1 : (flush_ack ? 1'b0 : flag_q);

        @(posedge clk_i);
        #1;
        check_val("flushing_o", 64'(new_flag), 64'(flushing));
        check_val("tohost_valid_o", 64'(prev_th), 64'(tohost_valid));
        if (prev_th) begin
            check_val("tohost_data_o", prev_td, tohost_data);
        end
        for (int p = 0; p < NP; p++) begin
            check_val({names[p], "_rvalid_o"}, 64'(exp_v[p]), 64'(rvalid[p]));
            if (exp_v[p]) begin
                check_val({names[p], "_rdata_o"}, exp_d[p], rdata[p]);
                check_val({names[p], "_err_o"}, 64'(exp_e[p]), 64'(err[p]));
            end
        end
        flag_q = new_flag;
        prev_hit = hit;
        prev_th = th;
        prev_td = tdat;
        exp_v = nv;
        exp_d = nd;
        exp_e = ne;
        clear_inputs();
    endtask

    task automatic drive(int p, logic w, logic [31:0] a, logic [7:0] b, logic [63:0] d);
        req[p] = 1'b1;
        we[p] = w;
        addr[p] = a;
        be[p] = b;
        wdata[p] = d;
    endtask

    task automatic idle(int n);
        repeat (n) step();
    endtask

    task automatic wait_flag(logic val, int limit);
        int n;
        n = 0;
        while (flushing !== val && n < limit) begin
            step();
            n++;
        end
        if (flushing !== val) begin
            $display("Timeout waiting for flushing_o to become %0b", val);
            errors++;
        end
    endtask

    task automatic end_test(string name);
        $display("Test %s done with %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        int n;
        logic [31:0] a;
        clear_inputs();
        flag_q = 1'b0;
        prev_hit = 1'b0;
        prev_th = 1'b0;
        prev_td = '0;
        for (int p = 0; p < NP; p++) begin
            exp_v[p] = 1'b0;
            exp_d[p] = '0;
            exp_e[p] = 1'b0;
        end
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // Preload every word, three per cycle
        for (int w = 0; w < WORDS; w += NP) begin
            for (int p = 0; p < NP; p++) begin
                if (w + p < WORDS) begin
                    a = {`MEM_BASE_TAG, 10'(w + p), 3'b000};
                    drive(p, 1'b1, a, 8'hFF, fill_word(w + p));
                end
            end
            step();
        end
        end_test("preload");

        // Narrow address mask forces same-word reads and writes
        for (int i = 0; i < 400; i++) begin
            for (int p = 0; p < NP; p++) begin
                if (($random(seed) & 3) != 0) begin
                    a = (($random(seed) & 15) == 0) ? rand_oor()
                        : rand_addr((i % 2 == 0) ? 10'h00F : 10'h3FF);
                    drive(p, 1'($random(seed)), a, 8'hFF, {$random(seed), $random(seed)});
                end
            end
            step();
        end
        end_test("random_rw");

        for (int i = 0; i < 200; i++) begin
            for (int p = 0; p < NP; p++) begin
                a = rand_addr(10'h01F);
                drive(p, 1'($random(seed)), a, (($random(seed) & 3) == 0) ? 8'h00
                      : 8'($random(seed)), {$random(seed), $random(seed)});
            end
            step();
        end
        end_test("byte_enables");

        for (int i = 0; i < 100; i++) begin
            a = rand_addr(10'h3FF);
            n = ($random(seed) & 3);
            for (int p = 0; p < NP; p++) begin
                if (p != n) begin
                    drive(p, 1'b1, a, 8'($random(seed)) | 8'h01, {$random(seed), $random(seed)});
                end
            end
            step();
            drive(1, 1'b0, a, 8'hFF, '0);
            step();
        end
        end_test("collisions");

        for (int i = 0; i < 100; i++) begin
            a = rand_oor();
            drive(1, 1'($random(seed)), a, 8'hFF, {$random(seed), $random(seed)});
            step();
            // In-range alias read one cycle later sees any stray write
            drive(2, 1'b0, {`MEM_BASE_TAG, a[12:0]}, 8'hFF, '0);
            step();
        end
        end_test("out_of_range");

        // Preload hit the host words, so the flag starts out set
        flush_ack = 1'b1;
        step();
        wait_flag(1'b0, 8);
        // Instruction writes are not snooped
        drive(0, 1'b1, `TOHOST_ADDR, 8'hFF, 64'h1111_2222_3333_4444);
        idle(4);
        drive(1, 1'b1, `TOHOST_ADDR, 8'h3C, 64'hDEAD_BEEF_CAFE_F00D);
        wait_flag(1'b1, 8);
        flush_ack = 1'b1;
        step();
        wait_flag(1'b0, 8);
        drive(2, 1'b1, `FROMHOST_ADDR + 32'h4, 8'hFF, 64'h0123_4567_89AB_CDEF);
        wait_flag(1'b1, 8);
        flush_ack = 1'b1;
        step();
        drive(2, 1'b1, `TOHOST_ADDR, 8'hF0, 64'hA5A5_5A5A_0F0F_F0F0);
        idle(3);
        flush_ack = 1'b1;
        step();
        wait_flag(1'b0, 8);
        end_test("host_words");

        flush_req = 1'b1;
        step();
        wait_flag(1'b1, 8);
        flush_req = 1'b1;
        flush_ack = 1'b1;
        step();
        flush_ack = 1'b1;
        step();
        wait_flag(1'b0, 8);
        end_test("flush_req_ack");

        // Drain outstanding responses
        n = 0;
        while ((rvalid[0] || rvalid[1] || rvalid[2]) && n < 10) begin
            step();
            n++;
        end
        if (rvalid[0] || rvalid[1] || rvalid[2]) begin
            $display("Timeout waiting for responses to drain");
            errors++;
        end

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Hard limit on the whole run
    initial begin
        #2_000_000;
        $display("Simulation timeout reached");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
